// File: Makefile
TOP := chdr_ctrl_bridge_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module chdr_ctrl_bridge

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir -o sim_bin
	./obj_dir/sim_bin > sim.log 2>&1; cat sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hdl/axis_chdr_if.sv
// AXI-Stream bundle for one 64-bit CHDR link
`timescale 1ns/1ps

interface axis_chdr_if;

  import rfnoc_chdr_pkg::*;

  chdr_word_t tdata;
  logic       tlast;
  logic       tvalid;
  logic       tready;

  modport master (
    output tdata, tlast, tvalid,
    input  tready
  );

  modport slave (
    input  tdata, tlast, tvalid,
    output tready
  );

endinterface

// File: hdl/chdr_ctrl_bridge.sv
// CHDR to AXIS-Control bridge top level with register slices on both CHDR ports
`timescale 1ns/1ps

module chdr_ctrl_bridge (
  input  logic                       rfnoc_chdr_clk,
  input  logic                       rfnoc_chdr_rst,
  // CHDR in
  input  rfnoc_chdr_pkg::chdr_word_t i_chdr_tdata,
  input  logic                       i_chdr_tlast,
  input  logic                       i_chdr_tvalid,
  output logic                       o_chdr_tready,
  // CHDR out
  output rfnoc_chdr_pkg::chdr_word_t o_chdr_tdata,
  output logic                       o_chdr_tlast,
  output logic                       o_chdr_tvalid,
  input  logic                       i_chdr_tready,
  // Control in
  input  rfnoc_ctrl_pkg::ctrl_word_t i_ctrl_tdata,
  input  logic                       i_ctrl_tlast,
  input  logic                       i_ctrl_tvalid,
  output logic                       o_ctrl_tready,
  // Control out
  output rfnoc_ctrl_pkg::ctrl_word_t o_ctrl_tdata,
  output logic                       o_ctrl_tlast,
  output logic                       o_ctrl_tvalid,
  input  logic                       i_ctrl_tready
);

  axis_chdr_if chdr_port_in_if ();
  axis_chdr_if chdr_in_if ();
  axis_chdr_if chdr_out_if ();
  axis_chdr_if chdr_port_out_if ();

  // ------------------------------------------------
  // CHDR port wiring
  // ------------------------------------------------
  assign chdr_port_in_if.tdata  = i_chdr_tdata;
  assign chdr_port_in_if.tlast  = i_chdr_tlast;
  assign chdr_port_in_if.tvalid = i_chdr_tvalid;
  assign o_chdr_tready          = chdr_port_in_if.tready;

  assign o_chdr_tdata            = chdr_port_out_if.tdata;
  assign o_chdr_tlast            = chdr_port_out_if.tlast;
  assign o_chdr_tvalid           = chdr_port_out_if.tvalid;
  assign chdr_port_out_if.tready = i_chdr_tready;

  // ------------------------------------------------
  // CHDR to control
  // ------------------------------------------------
  chdr_reg_slice in_slice (
    .i_clk (rfnoc_chdr_clk),
    .i_rst (rfnoc_chdr_rst),
    .s     (chdr_port_in_if),
    .m     (chdr_in_if)
  );

  chdr_ctrl_extract u_extract (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .s_chdr         (chdr_in_if),
    .o_ctrl_tdata   (o_ctrl_tdata),
    .o_ctrl_tlast   (o_ctrl_tlast),
    .o_ctrl_tvalid  (o_ctrl_tvalid),
    .i_ctrl_tready  (i_ctrl_tready)
  );

  // ------------------------------------------------
  // Control to CHDR
  // ------------------------------------------------
  ctrl_chdr_frame u_frame (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .i_ctrl_tdata   (i_ctrl_tdata),
    .i_ctrl_tlast   (i_ctrl_tlast),
    .i_ctrl_tvalid  (i_ctrl_tvalid),
    .o_ctrl_tready  (o_ctrl_tready),
    .m_chdr         (chdr_out_if)
  );

  chdr_reg_slice out_slice (
    .i_clk (rfnoc_chdr_clk),
    .i_rst (rfnoc_chdr_rst),
    .s     (chdr_out_if),
    .m     (chdr_port_out_if)
  );

endmodule

// File: hdl/chdr_ctrl_extract.sv
// CHDR to AXIS-Control path: strips header and metadata, splits lines into words
`timescale 1ns/1ps

module chdr_ctrl_extract (
  input  logic                    rfnoc_chdr_clk,
  input  logic                    rfnoc_chdr_rst,
  axis_chdr_if.slave              s_chdr,
  output rfnoc_ctrl_pkg::ctrl_word_t o_ctrl_tdata,
  output logic                    o_ctrl_tlast,
  output logic                    o_ctrl_tvalid,
  input  logic                    i_ctrl_tready
);

  import rfnoc_chdr_pkg::*;
  import rfnoc_ctrl_pkg::*;

  typedef enum logic [1:0] {
    ST_HEADER,
    ST_MDATA,
    ST_BODY
  } state_t;

  state_t       state;
  chdr_nmdata_t mdata_cnt;
  chdr_len_t    words_left;
  logic         half;
  chdr_header_t in_hdr;
  chdr_len_t    payload_words;
  logic         skip_high;
  logic         line_done;
  logic         chdr_xfer;
  logic         ctrl_xfer;

  // ------------------------------------------------
  // Header decode
  // ------------------------------------------------
  assign in_hdr = chdr_unpack_header(s_chdr.tdata);

  // Payload bytes = length - header - metadata, 4 bytes per word
  assign payload_words =
    (in_hdr.length - 16'd8 - {6'd0, in_hdr.num_mdata, 3'd0}) >> 2;

  // ------------------------------------------------
  // 64 to 32 splitter
  // ------------------------------------------------
  // Odd count: final line carries only its low word
  assign skip_high = !half && (words_left == 16'd1);
  assign line_done = half || skip_high;

  assign o_ctrl_tvalid = (state == ST_BODY) && s_chdr.tvalid;
  assign o_ctrl_tdata  = half ? ctrl_hi_word(s_chdr.tdata) : ctrl_lo_word(s_chdr.tdata);
  assign o_ctrl_tlast  = s_chdr.tlast && line_done;

  // Header and metadata lines are consumed without output
  assign s_chdr.tready = (state == ST_BODY) ? (i_ctrl_tready && line_done) : 1'b1;

  assign chdr_xfer = s_chdr.tvalid && s_chdr.tready;
  assign ctrl_xfer = o_ctrl_tvalid && i_ctrl_tready;

  // ------------------------------------------------
  // Packet FSM
  // ------------------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      state      <= ST_HEADER;
      mdata_cnt  <= '0;
      words_left <= '0;
      half       <= 1'b0;
    end else begin
      if (ctrl_xfer) begin
        half       <= !line_done;
        words_left <= words_left - 16'd1;
      end
      if (chdr_xfer) begin
        case (state)
          ST_HEADER: begin
            mdata_cnt  <= in_hdr.num_mdata - 7'd1;
            words_left <= payload_words;
            half       <= 1'b0;
            // Early tlast means a truncated packet, drop it
            if (!s_chdr.tlast) begin
              state <= (in_hdr.num_mdata == 7'd0) ? ST_BODY : ST_MDATA;
            end
          end
          ST_MDATA: begin
            mdata_cnt <= mdata_cnt - 7'd1;
            if (s_chdr.tlast) begin
              state <= ST_HEADER;
            end else if (mdata_cnt == 7'd0) begin
              state <= ST_BODY;
            end
          end
          ST_BODY: begin
            if (s_chdr.tlast) begin
              state <= ST_HEADER;
            end
          end
          default: begin
            state <= ST_HEADER;
          end
        endcase
      end
    end
  end

endmodule

// File: hdl/chdr_ctrl_settings.svh
// Bus width settings shared by the CHDR to AXIS-Control bridge
`ifndef CHDR_CTRL_SETTINGS_SVH
`define CHDR_CTRL_SETTINGS_SVH

// CHDR line width in bits
`define CHDR_W 64

// AXIS-Control word width in bits
`define CTRL_W 32

`endif

// File: hdl/chdr_reg_slice.sv
// One-entry AXI-Stream register slice for a CHDR link
`timescale 1ns/1ps

module chdr_reg_slice (
  input  logic        i_clk,
  input  logic        i_rst,
  axis_chdr_if.slave  s,
  axis_chdr_if.master m
);

  import rfnoc_chdr_pkg::*;

  chdr_word_t data_q;
  logic       last_q;
  logic       full_q;
  logic       s_xfer;

  // ------------------------------------------------
  // Handshake
  // ------------------------------------------------
  // Accept when empty, or when the held beat leaves this cycle
  assign s.tready = !full_q || m.tready;
  assign s_xfer   = s.tvalid && s.tready;

  assign m.tvalid = full_q;
  assign m.tdata  = data_q;
  assign m.tlast  = last_q;

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      full_q <= 1'b0;
    end else if (s_xfer) begin
      full_q <= 1'b1;
    end else if (m.tready) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (s_xfer) begin
      data_q <= s.tdata;
      last_q <= s.tlast;
    end
  end

endmodule

// File: hdl/ctrl_chdr_frame.sv
// AXIS-Control to CHDR path: packs word pairs and prepends a control header
`timescale 1ns/1ps

module ctrl_chdr_frame (
  input  logic                       rfnoc_chdr_clk,
  input  logic                       rfnoc_chdr_rst,
  input  rfnoc_ctrl_pkg::ctrl_word_t i_ctrl_tdata,
  input  logic                       i_ctrl_tlast,
  input  logic                       i_ctrl_tvalid,
  output logic                       o_ctrl_tready,
  axis_chdr_if.master                m_chdr
);

  import rfnoc_chdr_pkg::*;
  import rfnoc_ctrl_pkg::*;

  typedef enum logic {
    ST_HEADER,
    ST_BODY
  } state_t;

  ctrl_word_t      lo_q;
  logic            lo_full;
  chdr_word_t      line_q;
  logic            line_last_q;
  logic            line_valid_q;
  state_t          state;
  chdr_seq_t       seq_q;
  ctrl_line_info_t info;
  chdr_word_t      hdr_word;
  logic            in_xfer;
  logic            line_take;
  logic            out_xfer;

  // ------------------------------------------------
  // 32 to 64 packer
  // ------------------------------------------------
  assign line_take     = line_valid_q && m_chdr.tready && (state == ST_BODY);
  assign o_ctrl_tready = !line_valid_q || line_take;
  assign in_xfer       = i_ctrl_tvalid && o_ctrl_tready;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      lo_full      <= 1'b0;
      line_valid_q <= 1'b0;
    end else begin
      if (line_take) begin
        line_valid_q <= 1'b0;
      end
      if (in_xfer) begin
        if (lo_full) begin
          lo_full      <= 1'b0;
          line_valid_q <= 1'b1;
        end else if (i_ctrl_tlast) begin
          line_valid_q <= 1'b1;
        end else begin
          lo_full <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (in_xfer) begin
      if (lo_full) begin
        line_q      <= {i_ctrl_tdata, lo_q};
        line_last_q <= i_ctrl_tlast;
      end else if (i_ctrl_tlast) begin
        // Odd last word, upper half padded with zeros
        line_q      <= {ctrl_word_t'(0), i_ctrl_tdata};
        line_last_q <= 1'b1;
      end else begin
        lo_q <= i_ctrl_tdata;
      end
    end
  end

  // ------------------------------------------------
  // Header builder
  // ------------------------------------------------
  // line_q holds the first packed line while in ST_HEADER
  assign info     = ctrl_get_line_info(line_q);
  assign hdr_word = chdr_pack_header(chdr_build_header(
    6'd0, CHDR_PKT_CTRL, 7'd0, seq_q, ctrl_chdr_len(info), info.epid));

  assign m_chdr.tvalid = line_valid_q;
  assign m_chdr.tdata  = (state == ST_HEADER) ? hdr_word : line_q;
  assign m_chdr.tlast  = (state == ST_BODY) && line_last_q;
  assign out_xfer      = m_chdr.tvalid && m_chdr.tready;

  // ------------------------------------------------
  // Output FSM and sequence counter
  // ------------------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      state <= ST_HEADER;
      seq_q <= '0;
    end else if (out_xfer) begin
      case (state)
        ST_HEADER: state <= ST_BODY;
        ST_BODY: begin
          if (m_chdr.tlast) begin
            state <= ST_HEADER;
            seq_q <= seq_q + 16'd1;
          end
        end
        default: state <= ST_HEADER;
      endcase
    end
  end

endmodule

// File: hdl/rfnoc_chdr_pkg.sv
// CHDR types, header layout and header pack/unpack helpers
`include "chdr_ctrl_settings.svh"

package rfnoc_chdr_pkg;

  typedef logic [`CHDR_W-1:0] chdr_word_t;
  typedef logic [15:0]        chdr_len_t;
  typedef logic [15:0]        chdr_seq_t;
  typedef logic [15:0]        chdr_epid_t;
  typedef logic [6:0]         chdr_nmdata_t;

  typedef enum logic [2:0] {
    CHDR_PKT_MGMT       = 3'd0,
    CHDR_PKT_STRS       = 3'd1,
    CHDR_PKT_STRC       = 3'd2,
    CHDR_PKT_CTRL       = 3'd4,
    CHDR_PKT_DATA_NO_TS = 3'd6,
    CHDR_PKT_DATA_TS    = 3'd7
  } chdr_pkt_type_e;

  typedef struct packed {
    logic [5:0]     flags;
    chdr_pkt_type_e pkt_type;
    chdr_nmdata_t   num_mdata;
    chdr_seq_t      seq_num;
    chdr_len_t      length;
    chdr_epid_t     dst_epid;
  } chdr_header_t;

  // Field LSB positions within the 64-bit header line
  localparam int HDR_FLAGS_LSB  = 58;
  localparam int HDR_TYPE_LSB   = 55;
  localparam int HDR_NMDATA_LSB = 48;
  localparam int HDR_SEQ_LSB    = 32;
  localparam int HDR_LEN_LSB    = 16;
  localparam int HDR_EPID_LSB   = 0;

  function automatic chdr_header_t chdr_build_header(
    input logic [5:0]     flags,
    input chdr_pkt_type_e pkt_type,
    input chdr_nmdata_t   num_mdata,
    input chdr_seq_t      seq_num,
    input chdr_len_t      length,
    input chdr_epid_t     dst_epid
  );
    chdr_header_t hdr;
    hdr.flags     = flags;
    hdr.pkt_type  = pkt_type;
    hdr.num_mdata = num_mdata;
    hdr.seq_num   = seq_num;
    hdr.length    = length;
    hdr.dst_epid  = dst_epid;
    return hdr;
  endfunction

  function automatic chdr_word_t chdr_pack_header(input chdr_header_t hdr);
    chdr_word_t word;
    word = '0;
    word[HDR_FLAGS_LSB  +: 6]  = hdr.flags;
    word[HDR_TYPE_LSB   +: 3]  = hdr.pkt_type;
    word[HDR_NMDATA_LSB +: 7]  = hdr.num_mdata;
    word[HDR_SEQ_LSB    +: 16] = hdr.seq_num;
    word[HDR_LEN_LSB    +: 16] = hdr.length;
    word[HDR_EPID_LSB   +: 16] = hdr.dst_epid;
    return word;
  endfunction

  function automatic chdr_header_t chdr_unpack_header(input chdr_word_t word);
    chdr_header_t hdr;
    hdr.flags     = word[HDR_FLAGS_LSB +: 6];
    hdr.pkt_type  = chdr_pkt_type_e'(word[HDR_TYPE_LSB +: 3]);
    hdr.num_mdata = word[HDR_NMDATA_LSB +: 7];
    hdr.seq_num   = word[HDR_SEQ_LSB +: 16];
    hdr.length    = word[HDR_LEN_LSB +: 16];
    hdr.dst_epid  = word[HDR_EPID_LSB +: 16];
    return hdr;
  endfunction

endpackage

// File: hdl/rfnoc_ctrl_pkg.sv
// AXIS-Control word types and helpers for the first packed control line
`include "chdr_ctrl_settings.svh"

package rfnoc_ctrl_pkg;

  import rfnoc_chdr_pkg::*;

  typedef logic [`CTRL_W-1:0] ctrl_word_t;
  typedef logic [3:0]         ctrl_ndata_t;

  typedef struct packed {
    logic        has_time;
    ctrl_ndata_t num_data;
    chdr_epid_t  epid;
  } ctrl_line_info_t;

  // Control words within one CHDR line, low half first
  function automatic ctrl_word_t ctrl_lo_word(input chdr_word_t line);
    return line[`CTRL_W-1:0];
  endfunction

  function automatic ctrl_word_t ctrl_hi_word(input chdr_word_t line);
    return line[2*`CTRL_W-1:`CTRL_W];
  endfunction

  // First line holds control header word 0 low and word 1 high
  function automatic ctrl_line_info_t ctrl_get_line_info(input chdr_word_t line);
    ctrl_line_info_t info;
    info.has_time = line[30];
    info.num_data = line[23:20];
    info.epid     = line[`CTRL_W +: 16];
    return info;
  endfunction

  // 8 header bytes plus 4 bytes per control word
  function automatic chdr_len_t ctrl_chdr_len(input ctrl_line_info_t info);
    chdr_len_t nwords;
    nwords = 16'd3 + (info.has_time ? 16'd2 : 16'd0) + {12'd0, info.num_data};
    return 16'd8 + (nwords << 2);
  endfunction

endpackage

// File: sim.f
+incdir+hdl
hdl/rfnoc_chdr_pkg.sv
hdl/rfnoc_ctrl_pkg.sv
hdl/axis_chdr_if.sv
hdl/chdr_reg_slice.sv
hdl/chdr_ctrl_extract.sv
hdl/ctrl_chdr_frame.sv
hdl/chdr_ctrl_bridge.sv
tb/chdr_ctrl_bridge_sva.sv
tb/chdr_ctrl_bridge_tb.sv

// File: tb/chdr_ctrl_bridge_sva.sv
// Handshake stability and reset assertions bound to the bridge top level
`timescale 1ns/1ps

module chdr_ctrl_bridge_sva (
  input logic        rfnoc_chdr_clk,
  input logic        rfnoc_chdr_rst,
  input logic [63:0] o_chdr_tdata,
  input logic        o_chdr_tlast,
  input logic        o_chdr_tvalid,
  input logic        i_chdr_tready,
  input logic [31:0] o_ctrl_tdata,
  input logic        o_ctrl_tlast,
  input logic        o_ctrl_tvalid,
  input logic        i_ctrl_tready
);

  // Stalled outputs hold their beat
  a_chdr_stable: assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    (o_chdr_tvalid && !i_chdr_tready) |=>
      (o_chdr_tvalid && $stable(o_chdr_tdata) && $stable(o_chdr_tlast)))
    else $error("CHDR output changed while stalled");

  a_ctrl_stable: assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    (o_ctrl_tvalid && !i_ctrl_tready) |=>
      (o_ctrl_tvalid && $stable(o_ctrl_tdata) && $stable(o_ctrl_tlast)))
    else $error("Control output changed while stalled");

  // No valid in reset or in the cycle after
  a_reset_quiet: assert property (@(posedge rfnoc_chdr_clk)
    ((rfnoc_chdr_rst && $past(rfnoc_chdr_rst)) || $fell(rfnoc_chdr_rst)) |->
      (!o_chdr_tvalid && !o_ctrl_tvalid))
    else $error("Output valid during or right after reset");

endmodule

bind chdr_ctrl_bridge chdr_ctrl_bridge_sva u_sva (
  .rfnoc_chdr_clk (rfnoc_chdr_clk),
  .rfnoc_chdr_rst (rfnoc_chdr_rst),
  .o_chdr_tdata   (o_chdr_tdata),
  .o_chdr_tlast   (o_chdr_tlast),
  .o_chdr_tvalid  (o_chdr_tvalid),
  .i_chdr_tready  (i_chdr_tready),
  .o_ctrl_tdata   (o_ctrl_tdata),
  .o_ctrl_tlast   (o_ctrl_tlast),
  .o_ctrl_tvalid  (o_ctrl_tvalid),
  .i_ctrl_tready  (i_ctrl_tready)
);

// File: tb/chdr_ctrl_bridge_tb.sv
// Directed testbench for the CHDR to AXIS-Control bridge with queue-based checking
`timescale 1ns/1ps

module chdr_ctrl_bridge_tb;

  import rfnoc_chdr_pkg::*;
  import rfnoc_ctrl_pkg::*;

  // Beat budget over all tests for the watchdog
  localparam int TEST_BEATS = 150;

  logic rfnoc_chdr_clk;
  logic rfnoc_chdr_rst;
  chdr_word_t i_chdr_tdata, o_chdr_tdata;
  logic i_chdr_tlast, i_chdr_tvalid, o_chdr_tready;
  logic o_chdr_tlast, o_chdr_tvalid, i_chdr_tready;
  ctrl_word_t i_ctrl_tdata, o_ctrl_tdata;
  logic i_ctrl_tlast, i_ctrl_tvalid, o_ctrl_tready;
  logic o_ctrl_tlast, o_ctrl_tvalid, i_ctrl_tready;

  integer seed = 53;
  int mismatch_errs = 0;
  int other_errs = 0;
  bit stall_en = 0;
  bit chdr_first = 1;
  bit chdr_last = 0;
  string test_name = "reset";
  chdr_seq_t exp_seq = '0;
  ctrl_word_t exp_ctrl_q[$];
  bit exp_ctrl_last_q[$];
  chdr_word_t exp_chdr_q[$];
  bit exp_chdr_last_q[$];

  chdr_ctrl_bridge DUT (.*);

  always #2 rfnoc_chdr_clk = ~rfnoc_chdr_clk;

  // ------------------------------------------------
  // Compare tasks
  // ------------------------------------------------
  task automatic check_ctrl_word(input string name, input ctrl_word_t exp, input ctrl_word_t act);
    if (exp !== act) begin
      mismatch_errs++;
      $display("mismatch %s: ctrl word expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_chdr_header(input string name, input chdr_header_t exp,
                                   input chdr_header_t act);
    if (exp !== act) begin
      mismatch_errs++;
      $display("mismatch %s: chdr header expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_chdr_line(input string name, input chdr_word_t exp, input chdr_word_t act);
    if (exp !== act) begin
      mismatch_errs++;
      $display("mismatch %s: chdr line expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_last(input string name, input bit exp, input logic act);
    if (exp !== act) begin
      mismatch_errs++;
      $display("mismatch %s: tlast expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // ------------------------------------------------
  // Collectors drive ready on the falling edge
  // ------------------------------------------------
  always begin
    @(negedge rfnoc_chdr_clk);
    i_ctrl_tready = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
    #1;
    if (o_ctrl_tvalid && i_ctrl_tready) begin
      if (exp_ctrl_q.size() == 0) begin
        other_errs++;
        $display("%s: control word came out with none expected", test_name);
      end else begin
        check_ctrl_word(test_name, exp_ctrl_q.pop_front(), o_ctrl_tdata);
        check_last(test_name, exp_ctrl_last_q.pop_front(), o_ctrl_tlast);
      end
    end
  end

  always begin
    @(negedge rfnoc_chdr_clk);
    i_chdr_tready = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
    #1;
    if (o_chdr_tvalid && i_chdr_tready) begin
      if (exp_chdr_q.size() == 0) begin
        other_errs++;
        $display("%s: CHDR line came out with none expected", test_name);
      end else begin
        chdr_last = exp_chdr_last_q.pop_front();
        if (chdr_first) begin
          check_chdr_header(test_name, chdr_header_t'(exp_chdr_q.pop_front()),
                            chdr_header_t'(o_chdr_tdata));
        end else begin
          check_chdr_line(test_name, exp_chdr_q.pop_front(), o_chdr_tdata);
        end
        check_last(test_name, chdr_last, o_chdr_tlast);
        chdr_first = chdr_last;
      end
    end
  end

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------
  task automatic drive_chdr_beat(input chdr_word_t d, input bit last);
    @(negedge rfnoc_chdr_clk);
    i_chdr_tdata  = d;
    i_chdr_tlast  = last;
    i_chdr_tvalid = 1'b1;
    #1;
    while (!o_chdr_tready) begin
      @(negedge rfnoc_chdr_clk);
      #1;
    end
  endtask

  task automatic drive_ctrl_beat(input ctrl_word_t d, input bit last);
    @(negedge rfnoc_chdr_clk);
    i_ctrl_tdata  = d;
    i_ctrl_tlast  = last;
    i_ctrl_tvalid = 1'b1;
    #1;
    while (!o_ctrl_tready) begin
      @(negedge rfnoc_chdr_clk);
      #1;
    end
  endtask

  // Tlast lands on line cut_at unless cut_at is -1
  task automatic send_chdr_pkt(input int nmdata, input int nwords, input int cut_at);
    ctrl_word_t w[$];
    chdr_len_t len;
    int nlines;
    int idx;
    for (int i = 0; i < nwords; i++) begin
      w.push_back(ctrl_word_t'($random(seed)));
      if (cut_at < 0) begin
        exp_ctrl_q.push_back(w[i]);
        exp_ctrl_last_q.push_back(i == nwords - 1);
      end
    end
    len = 16'(8 + 8 * nmdata + 4 * nwords);
    nlines = 1 + nmdata + (nwords + 1) / 2;
    for (int l = 0; l < nlines; l++) begin
      if (l == 0) begin
        drive_chdr_beat({6'd0, 3'd4, 7'(nmdata), 16'h0042, len, 16'h0007}, cut_at == 0);
      end else if (l <= nmdata) begin
        drive_chdr_beat({32'hdead0000 | l, 32'(seed)}, cut_at == l);
      end else begin
        idx = 2 * (l - 1 - nmdata);
        // Unused high half gets junk that must be dropped
        drive_chdr_beat({(idx + 1 < nwords) ? w[idx + 1] : 32'hbad0bad0, w[idx]},
                        l == nlines - 1);
      end
      if (l == cut_at) break;
    end
    @(negedge rfnoc_chdr_clk);
    i_chdr_tvalid = 1'b0;
  endtask

  task automatic send_ctrl_pkt(input bit has_time, input int ndata);
    ctrl_word_t w[$];
    int n;
    n = 3 + (has_time ? 2 : 0) + ndata;
    w.push_back({1'b0, has_time, 6'd0, 4'(ndata), 4'h0, 16'h1234});
    w.push_back({16'(seed), 16'h00a0 + 16'(ndata)});
    for (int i = 2; i < n; i++) w.push_back(ctrl_word_t'($random(seed)));
    exp_chdr_q.push_back({6'd0, 3'd4, 7'd0, exp_seq, 16'(8 + 4 * n), w[1][15:0]});
    exp_chdr_last_q.push_back(1'b0);
    for (int k = 0; 2 * k < n; k++) begin
      exp_chdr_q.push_back({(2 * k + 1 < n) ? w[2 * k + 1] : 32'h0, w[2 * k]});
      exp_chdr_last_q.push_back(2 * k + 2 >= n);
    end
    exp_seq++;
    for (int i = 0; i < n; i++) drive_ctrl_beat(w[i], i == n - 1);
    @(negedge rfnoc_chdr_clk);
    i_ctrl_tvalid = 1'b0;
  endtask

  task automatic drain_queues();
    for (int i = 0; i < 500; i++) begin
      if (exp_ctrl_q.size() == 0 && exp_chdr_q.size() == 0) break;
      @(negedge rfnoc_chdr_clk);
    end
    if (exp_ctrl_q.size() != 0 || exp_chdr_q.size() != 0) begin
      other_errs++;
      $display("%s: %0d control words and %0d CHDR lines never came out",
               test_name, exp_ctrl_q.size(), exp_chdr_q.size());
      exp_ctrl_q.delete();
      exp_ctrl_last_q.delete();
      exp_chdr_q.delete();
      exp_chdr_last_q.delete();
    end
  endtask

  task automatic apply_reset();
    rfnoc_chdr_rst = 1'b1;
    exp_seq = '0;
    chdr_first = 1'b1;
    repeat (8) @(posedge rfnoc_chdr_clk);
    @(negedge rfnoc_chdr_clk);
    rfnoc_chdr_rst = 1'b0;
  endtask

  // ------------------------------------------------
  // Tests
  // ------------------------------------------------
  task automatic test_even_no_mdata();
    test_name = "even_no_mdata";
    send_chdr_pkt(0, 4, -1);
    drain_queues();
  endtask

  task automatic test_mdata_odd();
    test_name = "mdata_odd";
    send_chdr_pkt(1, 3, -1);
    send_chdr_pkt(3, 5, -1);
    drain_queues();
  endtask

  task automatic test_ctrl_no_time();
    test_name = "ctrl_no_time";
    send_ctrl_pkt(1'b0, 2);
    drain_queues();
  endtask

  task automatic test_ctrl_time_seq();
    test_name = "ctrl_time_seq";
    send_ctrl_pkt(1'b1, 1);
    send_ctrl_pkt(1'b1, 4);
    send_ctrl_pkt(1'b1, 7);
    drain_queues();
  endtask

  task automatic test_both_stalls();
    test_name = "both_stalls";
    stall_en = 1'b1;
    fork
      begin
        send_chdr_pkt(2, 6, -1);
        send_chdr_pkt(0, 3, -1);
      end
      begin
        send_ctrl_pkt(1'b0, 5);
        send_ctrl_pkt(1'b1, 0);
      end
    join
    drain_queues();
    stall_en = 1'b0;
  endtask

  task automatic test_truncated();
    test_name = "truncated";
    send_chdr_pkt(0, 4, 0);
    send_chdr_pkt(3, 4, 1);
    send_chdr_pkt(1, 5, -1);
    drain_queues();
  endtask

  initial begin
    #(TEST_BEATS * 20 * 4);
    $display("Watchdog expired while running %s", test_name);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    rfnoc_chdr_clk = 1'b0;
    i_chdr_tdata = '0;
    i_chdr_tlast = 1'b0;
    i_chdr_tvalid = 1'b0;
    i_chdr_tready = 1'b1;
    i_ctrl_tdata = '0;
    i_ctrl_tlast = 1'b0;
    i_ctrl_tvalid = 1'b0;
    i_ctrl_tready = 1'b1;
    apply_reset();
    test_even_no_mdata();
    test_mdata_odd();
    test_ctrl_no_time();
    apply_reset();
    test_ctrl_time_seq();
    test_both_stalls();
    test_truncated();
    $display("Errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
